// File: Makefile
TOP := imuldiv_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// File: logic/imuldiv_div_iterative.sv
/*
 iterative restoring divider, signed or unsigned
 returns remainder in the upper half and quotient in the lower half
*/

`timescale 1ns/100ps

module imuldiv_div_iterative (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [imuldiv_pkg::data_width-1:0]   req_a,
  input  logic [imuldiv_pkg::data_width-1:0]   req_b,
  input  logic                                 req_signed,
  input  logic                                 req_val,
  output logic                                 req_rdy,
  output logic [imuldiv_pkg::result_width-1:0] resp_result,
  output logic                                 resp_val,
  input  logic                                 resp_rdy
);
  import imuldiv_pkg::*;

  // ----------------------------------------
  // control
  // ----------------------------------------

  logic [state_width-1:0]   state;
  logic [state_width-1:0]   state_next;
  logic [counter_width-1:0] cnt_reg;
  logic                     req_go;
  logic                     resp_go;
  logic                     counter_is_zero;
  logic                     dp_en;
  logic                     dp_shift;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;
  assign counter_is_zero = (cnt_reg == '0);

  // same shape and timing as the multiplier
  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (req_go) state_next = st_calc;
      end
      st_calc: begin
        if (counter_is_zero) state_next = st_done;
      end
      st_done: begin
        if (resp_go) state_next = st_idle;
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      cnt_reg <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        cnt_reg <= counter_width'(iter_count - 1);
      end else if (state == st_calc && !counter_is_zero) begin
        cnt_reg <= cnt_reg - 1'b1;
      end
    end
  end

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign dp_en    = req_go || (state == st_calc);
  assign dp_shift = (state == st_calc);

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  logic                  a_neg;
  logic                  b_neg;
  logic [data_width-1:0] a_mag;
  logic [data_width-1:0] b_mag;
  // dividend bits shift out the top, quotient bits shift in the bottom
  logic [data_width-1:0] quo_reg;
  logic [data_width-1:0] rem_reg;
  logic [data_width-1:0] dvs_reg;
  logic                  neg_quo_reg;
  logic                  neg_rem_reg;
  logic [data_width:0]   rem_shifted;
  logic [data_width+1:0] rem_diff;
  logic                  fits;
  logic [data_width-1:0] quo_out;
  logic [data_width-1:0] rem_out;

  // operand signs only count in signed mode
  assign a_neg = req_signed && req_a[data_width-1];
  assign b_neg = req_signed && req_b[data_width-1];
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // trial subtract, one guard bit so the borrow shows up as the msb
  assign rem_shifted = {rem_reg, quo_reg[data_width-1]};
  assign rem_diff    = {1'b0, rem_shifted} - {2'b00, dvs_reg};
  assign fits        = ~rem_diff[data_width+1];

  always_ff @(posedge clk) begin
    if (dp_en) begin
      if (dp_shift) begin
        // restore by keeping the shifted value when the subtract borrows
        rem_reg <= fits ? rem_diff[data_width-1:0] : rem_shifted[data_width-1:0];
        quo_reg <= {quo_reg[data_width-2:0], fits};
      end else begin
        rem_reg     <= '0;
        quo_reg     <= a_mag;
        dvs_reg     <= b_mag;
        // zero divisor leaves the all-ones quotient alone
        neg_quo_reg <= (a_neg ^ b_neg) && (req_b != '0);
        neg_rem_reg <= a_neg;
      end
    end
  end

  // remainder follows the dividend sign
  assign quo_out     = neg_quo_reg ? (~quo_reg + 1'b1) : quo_reg;
  assign rem_out     = neg_rem_reg ? (~rem_reg + 1'b1) : rem_reg;
  assign resp_result = {rem_out, quo_out};

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  // response only leaves done on a transfer, payload frozen meanwhile
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result));

endmodule

// File: logic/imuldiv_mul_iterative.sv
/*
 iterative signed multiplier
 shift-and-add on operand magnitudes, one bit per cycle, sign restored on output
*/

`timescale 1ns/100ps

module imuldiv_mul_iterative (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [imuldiv_pkg::data_width-1:0]   req_a,
  input  logic [imuldiv_pkg::data_width-1:0]   req_b,
  input  logic                                 req_val,
  output logic                                 req_rdy,
  output logic [imuldiv_pkg::result_width-1:0] resp_result,
  output logic                                 resp_val,
  input  logic                                 resp_rdy
);
  import imuldiv_pkg::*;

  // ----------------------------------------
  // control
  // ----------------------------------------

  logic [state_width-1:0]   state;
  logic [state_width-1:0]   state_next;
  logic [counter_width-1:0] cnt_reg;
  logic                     req_go;
  logic                     resp_go;
  logic                     counter_is_zero;
  // register enable, shared by all datapath registers
  logic                     dp_en;
  // 0 loads fresh operands, 1 takes the shifted values
  logic                     dp_shift;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;
  assign counter_is_zero = (cnt_reg == '0);

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (req_go) state_next = st_calc;
      end
      st_calc: begin
        // last iteration happens on this edge
        if (counter_is_zero) state_next = st_done;
      end
      st_done: begin
        if (resp_go) state_next = st_idle;
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      cnt_reg <= '0;
    end else begin
      state <= state_next;
      if (req_go) begin
        cnt_reg <= counter_width'(iter_count - 1);
      end else if (state == st_calc && !counter_is_zero) begin
        cnt_reg <= cnt_reg - 1'b1;
      end
    end
  end

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);
  assign dp_en    = req_go || (state == st_calc);
  assign dp_shift = (state == st_calc);

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  logic [data_width-1:0]   a_mag;
  logic [data_width-1:0]   b_mag;
  logic [result_width-1:0] a_reg;
  logic [data_width-1:0]   b_reg;
  logic [result_width-1:0] sum_reg;
  logic                    neg_reg;

  // magnitude of the most negative value comes out right as unsigned
  assign a_mag = req_a[data_width-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[data_width-1] ? (~req_b + 1'b1) : req_b;

  always_ff @(posedge clk) begin
    if (dp_en) begin
      if (dp_shift) begin
        // add the shifted multiplicand when the low multiplier bit is set
        if (b_reg[0]) sum_reg <= sum_reg + a_reg;
        a_reg <= a_reg << 1;
        b_reg <= b_reg >> 1;
      end else begin
        a_reg   <= {{(result_width - data_width){1'b0}}, a_mag};
        b_reg   <= b_mag;
        sum_reg <= '0;
        neg_reg <= req_a[data_width-1] ^ req_b[data_width-1];
      end
    end
  end

  // product is negative when exactly one operand was
  assign resp_result = neg_reg ? (~sum_reg + 1'b1) : sum_reg;

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  // a pending response holds still until it is taken
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result));

  // counter only counts down while calc is active, no wrap past zero
  a_cnt_no_underflow: assert property (@(posedge clk) disable iff (reset)
    state == st_calc |=> cnt_reg <= $past(cnt_reg));

endmodule

// File: logic/imuldiv_pkg.sv
/*
 multiply/divide unit shared definitions
 function codes, datapath widths, iteration count and FSM encodings
*/

package imuldiv_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  localparam int data_width   = 32;
  // full product, or remainder:quotient
  localparam int result_width = 2 * data_width;
  localparam int fn_width     = 2;

  // ----------------------------------------
  // function codes
  // ----------------------------------------

  // code 3 is reserved and decodes as multiply
  localparam logic [fn_width-1:0] fn_mul  = 2'd0;
  localparam logic [fn_width-1:0] fn_div  = 2'd1;
  localparam logic [fn_width-1:0] fn_divu = 2'd2;

  // ----------------------------------------
  // iteration control
  // ----------------------------------------

  // one result bit per cycle
  localparam int iter_count    = 32;
  localparam int counter_width = 5;

  // idle/calc/done FSM shared by both arithmetic blocks
  localparam int                   state_width = 2;
  localparam logic [state_width-1:0] st_idle = 2'd0;
  localparam logic [state_width-1:0] st_calc = 2'd1;
  localparam logic [state_width-1:0] st_done = 2'd2;

endpackage

// File: logic/imuldiv_unit.sv
/*
 iterative multiply/divide unit top level
 steers each request to one arithmetic block and merges their responses
*/

`timescale 1ns/100ps

module imuldiv_unit (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic [imuldiv_pkg::fn_width-1:0]     req_fn,
  input  logic [imuldiv_pkg::data_width-1:0]   req_a,
  input  logic [imuldiv_pkg::data_width-1:0]   req_b,
  input  logic                                 req_val,
  output logic                                 req_rdy,
  output logic [imuldiv_pkg::result_width-1:0] resp_result,
  output logic                                 resp_val,
  input  logic                                 resp_rdy
);
  import imuldiv_pkg::*;

  logic                    is_div;
  logic                    div_signed;
  logic                    mul_req_val;
  logic                    mul_req_rdy;
  logic                    div_req_val;
  logic                    div_req_rdy;
  logic [result_width-1:0] mul_resp_result;
  logic [result_width-1:0] div_resp_result;
  logic                    mul_resp_val;
  logic                    div_resp_val;

  // ----------------------------------------
  // request steering
  // ----------------------------------------

  // reserved code falls through to multiply
  assign is_div     = (req_fn == fn_div) || (req_fn == fn_divu);
  assign div_signed = (req_fn == fn_div);

  // one operation in flight, so accept only with both blocks idle
  assign req_rdy     = mul_req_rdy && div_req_rdy;
  assign mul_req_val = req_val && req_rdy && !is_div;
  assign div_req_val = req_val && req_rdy && is_div;

  imuldiv_mul_iterative mul (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (resp_rdy)
  );

  imuldiv_div_iterative div (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_signed  (div_signed),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (resp_rdy)
  );

  // ----------------------------------------
  // response merge
  // ----------------------------------------

  // idle block ignores resp_rdy, so it can go to both
  assign resp_val    = mul_resp_val || div_resp_val;
  assign resp_result = div_resp_val ? div_resp_result : mul_resp_result;

  a_one_resp: assert property (@(posedge clk) disable iff (reset)
    !(mul_resp_val && div_resp_val));

endmodule

// File: sim/imuldiv_model.svh
/*
 reference model for the multiply/divide unit
 full signed product, and remainder:quotient with the divide special cases
*/

`ifndef imuldiv_model_svh
`define imuldiv_model_svh

// product of the sign-extended operands, all 64 bits kept
function automatic logic [result_width-1:0] model_mul(
  input logic [data_width-1:0] a,
  input logic [data_width-1:0] b
);
  longint pa;
  longint pb;
  pa = {{(result_width - data_width){a[data_width-1]}}, a};
  pb = {{(result_width - data_width){b[data_width-1]}}, b};
  return pa * pb;
endfunction

// remainder in the upper half, quotient in the lower half
function automatic logic [result_width-1:0] model_div(
  input logic [data_width-1:0] a,
  input logic [data_width-1:0] b,
  input logic                  is_signed
);
  logic [data_width-1:0] q;
  logic [data_width-1:0] r;
  if (b == '0) begin
    // divide by zero
    q = '1;
    r = a;
  end else if (is_signed && a == {1'b1, {(data_width - 1){1'b0}}} && b == '1) begin
    // most negative over minus one wraps back to itself
    q = a;
    r = '0;
  end else if (is_signed) begin
    // truncates toward zero, remainder keeps the dividend sign
    q = $signed(a) / $signed(b);
    r = $signed(a) % $signed(b);
  end else begin
    q = a / b;
    r = a % b;
  end
  return {r, q};
endfunction

// reserved code 3 behaves as multiply
function automatic logic [result_width-1:0] expected_result(
  input logic [fn_width-1:0]   fn,
  input logic [data_width-1:0] a,
  input logic [data_width-1:0] b
);
  if (fn == fn_div) return model_div(a, b, 1'b1);
  if (fn == fn_divu) return model_div(a, b, 1'b0);
  return model_mul(a, b);
endfunction

`endif

// File: sim/imuldiv_tb.sv
/*
 testbench for the multiply/divide unit
 corner and random requests under back-pressure, checked against a reference model
*/

`timescale 1ns/100ps

module imuldiv_tb;
  import imuldiv_pkg::*;

  `include "imuldiv_model.svh"

  localparam int num_ops        = 400;
  // every function over every pair of corner operands goes first
  localparam int num_directed   = 75;
  localparam int reset_cycles   = 16;
  // roughly 50 cycles per operation, gaps and stalls included
  localparam int timeout_cycles = reset_cycles + num_ops * 50;

  logic                    clk;
  logic                    reset;
  logic [fn_width-1:0]     req_fn;
  logic [data_width-1:0]   req_a;
  logic [data_width-1:0]   req_b;
  logic                    req_val;
  logic                    req_rdy;
  logic [result_width-1:0] resp_result;
  logic                    resp_val;
  logic                    resp_rdy;

  // expected results, oldest first
  logic [result_width-1:0] exp_q[$];
  logic [result_width-1:0] stalled_result;
  logic                    resp_stalled;
  logic                    resp_val_prev;
  int                      cycle_count;
  int                      accept_cycle;
  int                      accept_count;
  int                      resp_count;

  imuldiv_unit UUT (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #10 clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("Simulation failed");
    $fatal(1, "%s", what);
  endtask

  task automatic check_value(
    input logic [result_width-1:0] got,
    input logic [result_width-1:0] expected,
    input string                   what
  );
    if (got !== expected) begin
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
      stop_on_error("stopped at the first mismatch");
    end
  endtask

  // falling edge, where all inputs change
  task automatic next_cycle();
    @(negedge clk);
    // ready low on about one cycle in four
    resp_rdy = ($urandom_range(0, 3) != 0);
  endtask

  function automatic logic [data_width-1:0] corner_value(input int unsigned idx);
    case (idx)
      0: return '0;
      1: return data_width'(1);
      2: return '1;
      3: return {1'b1, {(data_width - 1){1'b0}}};
      default: return {1'b0, {(data_width - 1){1'b1}}};
    endcase
  endfunction

  function automatic logic [data_width-1:0] random_operand();
    if ($urandom_range(0, 3) == 0) return corner_value($urandom_range(0, 4));
    return $urandom();
  endfunction

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    int gap;
    void'($urandom(32'h9019_4dd0));
    clk = 1'b0;
    reset = 1'b1;
    req_fn = fn_mul;
    req_a = '0;
    req_b = '0;
    req_val = 1'b0;
    resp_rdy = 1'b0;
    resp_stalled = 1'b0;
    resp_val_prev = 1'b0;
    stalled_result = '0;
    cycle_count = 0;
    accept_cycle = 0;
    accept_count = 0;
    resp_count = 0;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    // idle unit straight out of reset
    check_value(result_width'(req_rdy), result_width'(1), "req_rdy after reset");
    check_value(result_width'(resp_val), result_width'(0), "resp_val after reset");
    for (int i = 0; i < num_ops; i++) begin
      gap = $urandom_range(0, 3);
      repeat (gap) next_cycle();
      if (i < num_directed) begin
        req_fn = fn_width'(i / 25);
        req_a  = corner_value((i / 5) % 5);
        req_b  = corner_value(i % 5);
      end else begin
        req_fn = fn_width'($urandom_range(0, 3));
        req_a  = random_operand();
        req_b  = random_operand();
      end
      // hold the request until the monitor sees it taken
      req_val = 1'b1;
      next_cycle();
      while (accept_count == i) next_cycle();
      req_val = 1'b0;
    end
    while (resp_count < num_ops) next_cycle();
    // a spurious extra response would appear within one operation time
    repeat (iter_count + 2) next_cycle();
    if (exp_q.size() == 0 && !resp_val && req_rdy) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_on_error("unit not idle after the last response, extra response or stuck busy");
    end
  end

  // ----------------------------------------
  // monitor, samples on the rising edge
  // ----------------------------------------

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      stop_on_error("timeout, the unit stopped making progress");
    end else if (!reset) begin
      // one operation in flight at most
      if (req_rdy) check_value(result_width'(exp_q.size()), '0, "req_rdy high while busy");
      if (resp_stalled) begin
        check_value(result_width'(resp_val), result_width'(1), "resp_val dropped on a stall");
        check_value(resp_result, stalled_result, "resp_result moved on a stall");
      end
      if (resp_val && !resp_val_prev) begin
        check_value(result_width'(cycle_count - accept_cycle), result_width'(iter_count + 1),
                    "cycles from accept to resp_val");
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          stop_on_error("response arrived with no request outstanding");
        end else begin
          check_value(resp_result, exp_q.pop_front(),
                      $sformatf("result of operation %0d", resp_count));
          resp_count++;
        end
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_fn, req_a, req_b));
        accept_cycle = cycle_count;
        accept_count++;
      end
      resp_stalled   = resp_val && !resp_rdy;
      stalled_result = resp_result;
      resp_val_prev  = resp_val;
    end
  end

endmodule

// File: src.f
+incdir+sim
logic/imuldiv_pkg.sv
logic/imuldiv_mul_iterative.sv
logic/imuldiv_div_iterative.sv
logic/imuldiv_unit.sv
sim/imuldiv_tb.sv
